// File: Bender.yml
package:
  name: arcade_io

sources:
  - hdl/arcade_io_pkg.sv
  - hdl/reset_enable_gen.sv
  - hdl/ps2_scan_decoder.sv
  - hdl/jamma_joy_mux.sv
  - hdl/board_out_stage.sv
  - hdl/arcade_io_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_arcade_io.sv

// File: flist.f
hdl/arcade_io_pkg.sv
hdl/reset_enable_gen.sv
hdl/ps2_scan_decoder.sv
hdl/jamma_joy_mux.sv
hdl/board_out_stage.sv
hdl/arcade_io_top.sv
testbench/tb_clock_gen.sv
testbench/tb_arcade_io.sv

// File: hdl/arcade_io_pkg.sv
package arcade_io_pkg;

  ////////////////////////////// widths
  localparam int color_bits       = 3;  // core colour depth per channel
  localparam int jamma_color_bits = 4;  // jamma edge connector colour depth
  localparam int joy_bits         = 8;  // full player word incl. start/spare
  localparam int local_joy_bits   = 6;  // board joystick, dirs + fire only
  localparam int scan_keys        = 21; // held-key switches to the core
  localparam int led_key          = 9;  // scan_sw bit mirrored on the led
  localparam int reset_delay_bits = 8;  // power-up hold counter, 256 cycles

  ////////////////////////////// types
  typedef logic [color_bits-1:0]       color_t;
  typedef logic [jamma_color_bits-1:0] jamma_color_t;
  typedef logic [joy_bits-1:0]         joy_t;        // active low, [7] start, [6] spare
  typedef logic [local_joy_bits-1:0]   local_joy_t;  // active low
  typedef logic [7:0]                  scancode_t;   // ps/2 set 2
  typedef logic [scan_keys-1:0]        scan_sw_t;    // 1 = key held

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
    logic   hsync;
    logic   vsync;
    logic   audio_l;   // 1-bit delta-sigma streams
    logic   audio_r;
  } av_out_t;

  typedef struct packed {
    joy_t player1;
    joy_t player2;
  } players_t;

  typedef enum logic [1:0] {idle, data, parity, stop} ps2_state_t;

  ////////////////////////////// keyboard map
  // index i drives scan_sw[i]; arrows share codes with keypad, E0 is ignored
  localparam scancode_t key_table [0:scan_keys-1] = '{
    8'h75, 8'h72, 8'h6B, 8'h74,  // up down left right
    8'h29, 8'h1A, 8'h16, 8'h1E,  // space, z, 1 (start1), 2 (start2)
    8'h2E, 8'h7E, 8'h1D, 8'h1B,  // 5 (coin), scroll lock (led), w, s
    8'h1C, 8'h23, 8'h15, 8'h24,  // a d q e
    8'h36, 8'h05, 8'h06, 8'h04,  // 6 (coin2), f1 f2 f3
    8'h0C                        // f4
  };

  localparam scancode_t key_break = 8'hF0;  // break prefix
  localparam scancode_t key_f12   = 8'h07;  // core reset
  localparam scancode_t key_ctrl  = 8'h14;
  localparam scancode_t key_alt   = 8'h11;
  localparam scancode_t key_bksp  = 8'h66;

endpackage

// File: hdl/arcade_io_top.sv
`timescale 1ns/1ps

module arcade_io_top #(
  parameter int joy_type = 1
) (
  input  logic                        pclk,
  input  logic                        pll_lckd,
  // board controls
  input  logic                        jtest,
  input  logic                        jservice,
  input  logic                        ps2_clk,
  input  logic                        ps2_data,
  input  arcade_io_pkg::joy_t         jjoy,
  input  arcade_io_pkg::local_joy_t   joystick,
  input  arcade_io_pkg::av_out_t      core_av,
  // to the core
  output logic                        ena_12,
  output logic                        ena_6,
  output logic                        core_reset,
  output arcade_io_pkg::scan_sw_t     scan_sw,
  output arcade_io_pkg::players_t     players,
  // to the board
  output logic                        jselect,
  output arcade_io_pkg::av_out_t      av_pins,
  output arcade_io_pkg::jamma_color_t jr,
  output arcade_io_pkg::jamma_color_t jg,
  output arcade_io_pkg::jamma_color_t jb,
  output logic                        jhsync,
  output logic                        jvsync,
  output logic                        jaudio,
  output logic                        led,
  output logic                        reboot
);

  logic reset_key;     // keyboard f12 into the core reset
  logic master_reset;  // keyboard request for multiboot

  ////////////////////////////// clocking / reset
  reset_enable_gen u_rst_ena (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .reset_key  (reset_key),
    .jtest      (jtest),
    .ena_12     (ena_12),
    .ena_6      (ena_6),
    .core_reset (core_reset)
  );

  ////////////////////////////// inputs
  ps2_scan_decoder u_ps2 (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .scan_sw      (scan_sw),
    .reset_key    (reset_key),
    .master_reset (master_reset)
  );

  jamma_joy_mux #(
    .joy_type (joy_type)
  ) u_joy (
    .pclk     (pclk),
    .pll_lckd (pll_lckd),
    .jjoy     (jjoy),
    .joystick (joystick),
    .jselect  (jselect),
    .players  (players)
  );

  ////////////////////////////// outputs
  board_out_stage u_out (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .core_av      (core_av),
    .scan_sw      (scan_sw),
    .master_reset (master_reset),
    .jservice     (jservice),
    .av_pins      (av_pins),
    .jr           (jr),
    .jg           (jg),
    .jb           (jb),
    .jhsync       (jhsync),
    .jvsync       (jvsync),
    .jaudio       (jaudio),
    .led          (led),
    .reboot       (reboot)
  );

endmodule

// File: hdl/board_out_stage.sv
`timescale 1ns/1ps

module board_out_stage (
  input  logic                        pclk,
  input  logic                        pll_lckd,
  input  arcade_io_pkg::av_out_t      core_av,       // straight from the core
  input  arcade_io_pkg::scan_sw_t     scan_sw,
  input  logic                        master_reset,
  input  logic                        jservice,      // active low
  output arcade_io_pkg::av_out_t      av_pins,       // vga pins + audio
  output arcade_io_pkg::jamma_color_t jr,
  output arcade_io_pkg::jamma_color_t jg,
  output arcade_io_pkg::jamma_color_t jb,
  output logic                        jhsync,
  output logic                        jvsync,
  output logic                        jaudio,
  output logic                        led,
  output logic                        reboot         // multiboot request
);

  import arcade_io_pkg::*;

  ////////////////////////////// pin registers
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      av_pins <= '0;
      led     <= 1'b0;
      reboot  <= 1'b0;
    end else begin
      av_pins <= core_av;                   // single stage to the io ring
      led     <= scan_sw[led_key];
      reboot  <= master_reset | ~jservice;  // keyboard or service button
    end
  end

  // jamma wants 4 bits, lsb tied low
  assign jr = {av_pins.red,   1'b0};
  assign jg = {av_pins.green, 1'b0};
  assign jb = {av_pins.blue,  1'b0};

  assign jhsync = av_pins.hsync;
  assign jvsync = av_pins.vsync;
  assign jaudio = av_pins.audio_l;  // mono cabinet, left channel only

endmodule

// File: hdl/jamma_joy_mux.sv
`timescale 1ns/1ps

module jamma_joy_mux #(
  parameter int joy_type = 1  // 1 jamma, 0 local joystick only
) (
  input  logic                      pclk,
  input  logic                      pll_lckd,
  input  arcade_io_pkg::joy_t       jjoy,      // shared jamma input bus
  input  arcade_io_pkg::local_joy_t joystick,  // board db9 joystick
  output logic                      jselect,   // 0 = player1 on the bus
  output arcade_io_pkg::players_t   players
);

  import arcade_io_pkg::*;

  joy_t     pad_joy;    // local stick with start/spare released
  logic     jsel_q;
  players_t players_q;

  assign pad_joy = {{(joy_bits-local_joy_bits){1'b1}}, joystick};

  ////////////////////////////// bus time-sharing
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      jsel_q    <= 1'b0;
      players_q <= '1;     // active low, nothing pressed
    end else if (joy_type == 1) begin
      jsel_q <= ~jsel_q;   // flip the select line every cycle
      // bus shows the player chosen by the current select
      if (!jsel_q)
        players_q.player1 <= jjoy & pad_joy;  // local stick wired in parallel
      else
        players_q.player2 <= jjoy;
    end else begin
      // no jamma harness, local stick only
      jsel_q            <= 1'b0;
      players_q.player1 <= pad_joy;
      players_q.player2 <= '1;
    end
  end

  assign jselect = jsel_q;
  assign players = players_q;

endmodule

// File: hdl/ps2_scan_decoder.sv
`timescale 1ns/1ps

module ps2_scan_decoder (
  input  logic                    pclk,
  input  logic                    pll_lckd,
  input  logic                    ps2_clk,       // open-collector keyboard clock
  input  logic                    ps2_data,
  output arcade_io_pkg::scan_sw_t scan_sw,       // held keys to the core
  output logic                    reset_key,     // f12 held
  output logic                    master_reset   // ctrl+alt+bksp held
);

  import arcade_io_pkg::*;

  logic [1:0] clk_sync;    // [1] is the synchronized ps2 clock
  logic [1:0] dat_sync;
  logic       clk_prev;
  logic       clk_fall;    // one pclk pulse per ps2 falling edge
  logic       dat_bit;

  ps2_state_t state;
  logic [2:0] bit_cnt;
  scancode_t  shift_q;     // lsb first, so shift in from the top
  logic       par_ok;
  logic       code_vld;    // shift_q holds a checked code for one cycle

  logic       break_pend;  // F0 seen, next code is a release
  logic       f12_held;
  logic       ctrl_held;
  logic       alt_held;
  logic       bksp_held;

  ////////////////////////////// input sync
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync <= 2'b11;  // bus idles high
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_data};
      clk_prev <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[1];
  assign dat_bit  = dat_sync[1];

  ////////////////////////////// frame receiver
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state    <= idle;
      bit_cnt  <= '0;
      code_vld <= 1'b0;
    end else begin
      code_vld <= 1'b0;
      if (clk_fall) begin
        case (state)
          idle: begin
            bit_cnt <= '0;
            if (!dat_bit)
              state <= data;       // start bit
          end
          data: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= parity;
          end
          parity: state <= stop;
          stop: begin
            state    <= idle;
            code_vld <= dat_bit & par_ok;  // bad stop or parity drops the frame
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // payload, qualified by state
  always_ff @(posedge pclk) begin
    if (clk_fall && state == data)
      shift_q <= {dat_bit, shift_q[7:1]};
    if (clk_fall && state == parity)
      par_ok <= ^{shift_q, dat_bit};       // odd parity over data + parity bit
  end

  ////////////////////////////// make / break decode
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      scan_sw    <= '0;
      break_pend <= 1'b0;
      f12_held   <= 1'b0;
      ctrl_held  <= 1'b0;
      alt_held   <= 1'b0;
      bksp_held  <= 1'b0;
    end else if (code_vld) begin
      if (shift_q == key_break) begin
        break_pend <= 1'b1;
      end else begin
        break_pend <= 1'b0;
        for (int i = 0; i < scan_keys; i++) begin
          if (shift_q == key_table[i])
            scan_sw[i] <= ~break_pend;     // make sets, break clears
        end
        // modifiers tracked on their own
        if (shift_q == key_f12)  f12_held  <= ~break_pend;
        if (shift_q == key_ctrl) ctrl_held <= ~break_pend;
        if (shift_q == key_alt)  alt_held  <= ~break_pend;
        if (shift_q == key_bksp) bksp_held <= ~break_pend;
      end
    end
  end

  assign reset_key    = f12_held;
  assign master_reset = ctrl_held & alt_held & bksp_held;  // three-finger salute

endmodule

// File: hdl/reset_enable_gen.sv
`timescale 1ns/1ps

module reset_enable_gen (
  input  logic pclk,
  input  logic pll_lckd,     // pll lock, doubles as async reset
  input  logic reset_key,    // f12 held on the keyboard
  input  logic jtest,        // jamma test switch, active low
  output logic ena_12,
  output logic ena_6,
  output logic core_reset
);

  import arcade_io_pkg::*;

  logic [reset_delay_bits-1:0] delay_cnt;  // free running, also the enable divider
  logic                        hold_q;     // power-up hold of the core

  ////////////////////////////// power-up delay
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      delay_cnt <= '0;
      hold_q    <= 1'b1;
    end else begin
      delay_cnt <= delay_cnt + 1'b1;  // wraps, keeps feeding the enables
      if (delay_cnt == '1)
        hold_q <= 1'b0;               // released after 256 cycles, stays low
    end
  end

  ////////////////////////////// clock enables
  // pclk/2 strobe
  assign ena_12 = delay_cnt[0];
  // pclk/4 strobe, coincides with every other ena_12
  assign ena_6  = delay_cnt[0] & ~delay_cnt[1];

  // keyboard and test switch can pull the core back into reset at any time
  assign core_reset = hold_q | reset_key | ~jtest;

endmodule

// File: testbench/arcade_io_patterns.txt
# all fields hex, one record per line, lines starting with # are comments
# R hold_cycles window ena6_count ena6_period
R 100 10 4 4
# K scancode break bad_parity exp_scan_sw
K 75 0 0 000001
K 1A 0 0 000021
K 7E 0 0 000221
K 1A 1 0 000201
K 29 0 1 000201
K 0C 0 0 100201
# P jtest jservice exp_core_reset exp_reboot exp_led
P 1 1 0 0 1
P 0 1 1 0 1
P 1 1 0 0 1
K 07 0 0 100201
P 1 1 1 0 1
K 07 1 0 100201
K 14 0 0 100201
K 11 0 0 100201
P 1 1 0 0 1
K 66 0 0 100201
P 1 1 0 1 1
K 11 1 0 100201
P 1 1 0 0 1
P 1 0 0 1 1
K 7E 1 0 100001
P 1 1 0 0 0
# J jjoy joystick exp_player1 exp_player2
J FF 3F FF FF
J FE 3F FE FE
J 7F 3E 7E 7F
J BD 1B 99 BD
J 5A 2C 48 5A
J FF 00 C0 FF
# V core_av exp_av_pins exp_jr exp_jg exp_jb exp_hsync_vsync_audio
V 1FFF 1FFF E E E 7
V 0000 0000 0 0 0 0
V 1555 1555 A 4 A 2
V 0AAA 0AAA 4 A 4 5
V 0C8A 0C8A 6 2 0 5

// File: testbench/tb_arcade_io.sv
`timescale 1ns/1ps

module tb_arcade_io;

  import arcade_io_pkg::*;

  localparam int ps2_phase  = 4;     // pclk cycles per ps/2 half bit
  localparam int lock_limit = 64;    // cycles allowed for pll lock
  localparam int hold_limit = 1024;  // cycles allowed for core_reset release
  localparam int max_lines  = 512;   // bounds the pattern loop

  logic         pclk;
  logic         pll_lckd;
  logic         jtest;
  logic         jservice;
  logic         ps2_clk;
  logic         ps2_data;
  joy_t         jjoy;
  local_joy_t   joystick;
  av_out_t      core_av;
  logic         ena_12;
  logic         ena_6;
  logic         core_reset;
  scan_sw_t     scan_sw;
  players_t     players;
  logic         jselect;
  av_out_t      av_pins;
  jamma_color_t jr;
  jamma_color_t jg;
  jamma_color_t jb;
  logic         jhsync;
  logic         jvsync;
  logic         jaudio;
  logic         led;
  logic         reboot;

  int           cycles_since_lock;  // pclk edges since lock, jselect follows its lsb

  tb_clock_gen u_clk (
    .pclk     (pclk),
    .pll_lckd (pll_lckd)
  );

  arcade_io_top #(
    .joy_type (1)
  ) u_dut (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .jtest      (jtest),
    .jservice   (jservice),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .jjoy       (jjoy),
    .joystick   (joystick),
    .core_av    (core_av),
    .ena_12     (ena_12),
    .ena_6      (ena_6),
    .core_reset (core_reset),
    .scan_sw    (scan_sw),
    .players    (players),
    .jselect    (jselect),
    .av_pins    (av_pins),
    .jr         (jr),
    .jg         (jg),
    .jb         (jb),
    .jhsync     (jhsync),
    .jvsync     (jvsync),
    .jaudio     (jaudio),
    .led        (led),
    .reboot     (reboot)
  );

  // select line starts at 0 on lock and flips on every edge after it
  always @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd)
      cycles_since_lock <= 0;
    else
      cycles_since_lock <= cycles_since_lock + 1;
  end

  ////////////////////////////// compares
  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      abort_run($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_scan_sw(input string name, input scan_sw_t exp, input scan_sw_t act);
    if (act !== exp)
      abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_players(input string name, input players_t exp, input players_t act);
    if (act !== exp)
      abort_run($sformatf("** Error %s: expected p1 %h p2 %h, actual p1 %h p2 %h",
                          name, exp.player1, exp.player2, act.player1, act.player2));
  endtask

  task automatic check_av(input string name, input av_out_t exp, input av_out_t act);
    if (act !== exp)
      abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_jamma_color(input string name, input jamma_color_t exp,
                                   input jamma_color_t act);
    if (act !== exp)
      abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic need_fields(input int got, input int want, input int line_no);
    if (got != want)
      abort_run($sformatf("pattern line %0d is missing fields", line_no));
  endtask

  ////////////////////////////// stimulus helpers
  // each step lands 2 ns after a rising edge
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge pclk);
      #2;
    end
  endtask

  // start, 8 data lsb first, odd parity, stop
  task automatic send_ps2_frame(input scancode_t code, input logic bad_parity);
    logic [10:0] frame;
    int          idx;
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    step_cycles(2 + $urandom % 12);  // random idle gap
    for (idx = 0; idx < 11; idx++) begin
      ps2_data = frame[idx];
      step_cycles(ps2_phase);        // data settles while clock is high
      ps2_clk = 1'b0;
      step_cycles(ps2_phase);        // last low phase = decode window
      ps2_clk = 1'b1;
    end
  endtask

  ////////////////////////////// pattern loop
  initial begin : stimulus
    int               fd;
    int               got;
    int               line_no;
    int               tests_run;
    int               seed;
    int               cnt;
    int               n6;
    int               last6;
    int               idx;
    logic [7:0]       kind;
    logic [31:0]      f1, f2, f3, f4, f5, f6;
    logic [8*128-1:0] skip_buf;
    av_out_t          last_av;
    players_t         exp_pl;

    jtest     = 1'b1;   // switches released
    jservice  = 1'b1;
    ps2_clk   = 1'b1;   // ps/2 bus idle
    ps2_data  = 1'b1;
    jjoy      = '1;
    joystick  = '1;
    core_av   = '0;
    last_av   = '0;
    seed      = $urandom(32'h1ca9);
    line_no   = 0;
    tests_run = 0;

    fd = $fopen("testbench/arcade_io_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/arcade_io_patterns.txt");
    end else begin
      got = $fscanf(fd, " %c", kind);
      while (got == 1 && line_no < max_lines) begin
        line_no++;
        case (kind)
          "#": got = $fgets(skip_buf, fd);  // comment line
          "R": begin
            got = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
            need_fields(got, 4, line_no);
            cnt = 0;
            while (pll_lckd !== 1'b1 && cnt < lock_limit) begin
              @(negedge pclk);
              cnt++;
            end
            if (pll_lckd !== 1'b1)
              abort_run("timeout: pll_lckd never went high");
            cnt = 0;
            while (core_reset === 1'b1 && cnt < hold_limit) begin
              cnt++;
              @(negedge pclk);
            end
            if (core_reset !== 1'b0)
              abort_run("timeout: core_reset was not released after lock");
            check_count($sformatf("line %0d reset hold", line_no), f1, cnt);
            n6    = 0;
            last6 = -1;
            // counter has just wrapped to 0, so ena_12 follows the cycle parity
            for (idx = 1; idx <= f2; idx++) begin
              @(negedge pclk);
              check_bit($sformatf("line %0d ena_12 toggle", line_no), idx[0], ena_12);
              if (ena_6) begin
                if (last6 >= 0)
                  check_count($sformatf("line %0d ena_6 period", line_no), f4, idx - last6);
                last6 = idx;
                n6++;
              end
            end
            check_count($sformatf("line %0d ena_6 count", line_no), f3, n6);
            tests_run++;
          end
          "K": begin
            got = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
            need_fields(got, 4, line_no);
            if (f2[0])
              send_ps2_frame(key_break, 1'b0);  // release prefix
            send_ps2_frame(f1[7:0], f3[0]);
            check_scan_sw($sformatf("line %0d scan_sw", line_no), f4[scan_keys-1:0], scan_sw);
            tests_run++;
          end
          "P": begin
            got = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
            need_fields(got, 5, line_no);
            step_cycles(1);
            jtest    = f1[0];
            jservice = f2[0];
            cnt = 0;
            while ({core_reset, reboot, led} !== {f3[0], f4[0], f5[0]} && cnt < 4) begin
              @(negedge pclk);
              cnt++;
            end
            check_bit($sformatf("line %0d core_reset", line_no), f3[0], core_reset);
            check_bit($sformatf("line %0d reboot", line_no), f4[0], reboot);
            check_bit($sformatf("line %0d led", line_no), f5[0], led);
            tests_run++;
          end
          "J": begin
            got = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
            need_fields(got, 4, line_no);
            step_cycles(1);
            jjoy     = f1[7:0];
            joystick = f2[5:0];
            exp_pl   = {f3[7:0], f4[7:0]};  // player1 is the upper byte
            cnt = 0;
            while (players !== exp_pl && cnt < 4) begin
              @(negedge pclk);
              cnt++;
            end
            check_players($sformatf("line %0d players", line_no), exp_pl, players);
            repeat (4) begin
              @(negedge pclk);
              check_bit($sformatf("line %0d jselect toggle", line_no),
                        cycles_since_lock[0], jselect);
            end
            tests_run++;
          end
          "V": begin
            got = $fscanf(fd, "%h %h %h %h %h %h", f1, f2, f3, f4, f5, f6);
            need_fields(got, 6, line_no);
            step_cycles(1);
            core_av = f1[$bits(av_out_t)-1:0];
            @(negedge pclk);   // same cycle, pins still hold the old value
            check_av($sformatf("line %0d av_pins before edge", line_no), last_av, av_pins);
            @(negedge pclk);   // one register stage later
            last_av = f2[$bits(av_out_t)-1:0];
            check_av($sformatf("line %0d av_pins", line_no), last_av, av_pins);
            check_jamma_color($sformatf("line %0d jr", line_no), f3[3:0], jr);
            check_jamma_color($sformatf("line %0d jg", line_no), f4[3:0], jg);
            check_jamma_color($sformatf("line %0d jb", line_no), f5[3:0], jb);
            check_bit($sformatf("line %0d jhsync", line_no), f6[2], jhsync);
            check_bit($sformatf("line %0d jvsync", line_no), f6[1], jvsync);
            check_bit($sformatf("line %0d jaudio", line_no), f6[0], jaudio);
            tests_run++;
          end
          default: abort_run($sformatf("unknown pattern kind on line %0d", line_no));
        endcase
        got = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
      if (tests_run == 0) begin
        abort_run("pattern file held no test lines");
      end else begin
        $display(">>> PASS");
        $finish;
      end
    end
  end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic pclk,
  output logic pll_lckd   // low while the pll is not locked
);

  localparam int half_period = 20;  // 40 ns pclk
  localparam int lock_cycles = 8;   // reset length in pclk cycles

  initial begin
    pclk = 1'b0;
    forever #(half_period) pclk = ~pclk;
  end

  // lock comes up just after a rising edge, same as the other stimulus
  initial begin
    pll_lckd = 1'b0;
    repeat (lock_cycles) @(posedge pclk);
    #2 pll_lckd = 1'b1;
  end

endmodule
